// File: Bender.yml
package:
  name: vec_alu

sources:
  - alu_pkg.sv
  - alu_stage_if.sv
  - alu_operand_prep.sv
  - alu_adder.sv
  - alu_result.sv
  - vec_alu.sv
  - target: test
    files:
      - vec_alu_checker.sv
      - tb_vec_alu.sv

// File: alu_adder.sv
// vector ALU stage two
// fracturable adder, per-element flags and saturation fill values
`timescale 1ns/10ps
`default_nettype none

module alu_adder #(
    parameter int unsigned OP_W = alu_pkg::OP_W
) (
    input  logic clk_i,
    input  logic async_rst_ni,
    ex1_if.dst   ex1_i,
    ex2_if.src   ex2_o
);

    localparam int unsigned NB = OP_W / 8;
    localparam int unsigned NS = OP_W / 32;

    logic [NS*37-1:0]    sum37;
    alu_pkg::ext_word_t  sum_d;
    logic [NB-1:0]       carry, sig_a, sig_b, sig_r, ovf, raw_flag;
    alu_pkg::byte_mask_t flag_d;
    alu_pkg::word_t      satval_d;
    alu_pkg::word_t      a_plain;
    alu_pkg::word_t      b_plain;
    logic                sub_op;
    logic                signed_sat;
    logic                stage_ready;
    logic                valid_q;

    assign sub_op     = alu_pkg::op_subtracts(ex1_i.op);
    assign signed_sat = (ex1_i.op == alu_pkg::OP_SADD) || (ex1_i.op == alu_pkg::OP_SSUB);

    //////////////////////////////
    // adder and raw flags

    always_comb begin
        for (int j = 0; j < NS; j++) begin
            sum37[37*j +: 37] = {1'b0, ex1_i.a_ext[36*j +: 36]} + {1'b0, ex1_i.b_ext[36*j +: 36]};
            sum_d[36*j +: 36] = sum37[37*j +: 36];
        end
        for (int k = 0; k < NB; k++) begin
            // carry out of byte k shows up in the chain bit of the lane above,
            // or in the slice carry-out for the last byte of a slice
            carry[k] = sum37[37*(k/4) + 9*(k%4) + 9];
            sig_a[k] = ex1_i.a_ext[9*k+8];
            sig_b[k] = ex1_i.b_ext[9*k+8];
            sig_r[k] = sum_d[9*k+8];
        end
    end

    // b is already inverted for subtraction, so the addition rule holds throughout
    assign ovf = ~(sig_a ^ sig_b) & (sig_a ^ sig_r);

    always_comb begin
        case (ex1_i.op)
            alu_pkg::OP_SADDU:                    raw_flag = carry;
            alu_pkg::OP_SSUBU:                    raw_flag = ~carry;
            alu_pkg::OP_SADD, alu_pkg::OP_SSUB:   raw_flag = ovf;
            // a below b means a borrow when unsigned and a sign corrected by overflow when signed
            alu_pkg::OP_SLTU, alu_pkg::OP_MINU,
            alu_pkg::OP_MAXU:                     raw_flag = ~carry;
            alu_pkg::OP_SLT, alu_pkg::OP_MIN,
            alu_pkg::OP_MAX:                      raw_flag = ovf ^ sig_r;
            default:                              raw_flag = '0;
        endcase
    end

    //////////////////////////////
    // per-element spread

    always_comb begin
        for (int k = 0; k < NB; k++) begin
            // every byte reads the flags of the top byte of its element
            int unsigned t;
            t         = k | alu_pkg::lane_mask(ex1_i.ew);
            flag_d[k] = raw_flag[t];
            if (signed_sat) begin
                // overflow flips the result sign, so the clamp is its inverse
                satval_d[8*k +: 8] = (k == t) ? {~sig_r[t], {7{sig_r[t]}}} : {8{sig_r[t]}};
            end else begin
                satval_d[8*k +: 8] = {8{carry[t]}};
            end
            a_plain[8*k +: 8] = ex1_i.a_ext[9*k+1 +: 8];
            b_plain[8*k +: 8] = sub_op ? ~ex1_i.b_ext[9*k+1 +: 8] : ex1_i.b_ext[9*k+1 +: 8];
        end
    end

    //////////////////////////////
    // stage register

    assign stage_ready = ~valid_q | ex2_o.ready;
    assign ex1_i.ready = stage_ready;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (stage_ready) begin
            valid_q <= ex1_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (stage_ready && ex1_i.valid) begin
            ex2_o.op     <= ex1_i.op;
            ex2_o.ew     <= ex1_i.ew;
            ex2_o.sum    <= sum_d;
            ex2_o.flag   <= flag_d;
            ex2_o.satval <= satval_d;
            ex2_o.a      <= a_plain;
            ex2_o.b      <= b_plain;
        end
    end

    assign ex2_o.valid = valid_q;

endmodule

`default_nettype wire

// File: alu_operand_prep.sv
// vector ALU stage one
// spreads the operands into nine-bit lanes with carry-chain control bits
`timescale 1ns/10ps
`default_nettype none

module alu_operand_prep #(
    parameter int unsigned OP_W = alu_pkg::OP_W
) (
    input  logic                 clk_i,
    input  logic                 async_rst_ni,
    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    input  alu_pkg::alu_op_e     op_i,
    input  alu_pkg::elem_width_e ew_i,
    input  alu_pkg::word_t       a_i,
    input  alu_pkg::word_t       b_i,
    ex1_if.src                   ex1_o
);

    localparam int unsigned NB = OP_W / 8;

    logic               sub_op;
    logic               valid_q;
    alu_pkg::ext_word_t a_ext_d;
    alu_pkg::ext_word_t b_ext_d;

    //////////////////////////////
    // lane expansion

    assign sub_op = alu_pkg::op_subtracts(op_i);

    always_comb begin
        for (int k = 0; k < NB; k++) begin
            a_ext_d[9*k+1 +: 8] = a_i[8*k +: 8];
            b_ext_d[9*k+1 +: 8] = sub_op ? ~b_i[8*k +: 8] : b_i[8*k +: 8];
            if ((k & alu_pkg::lane_mask(ew_i)) == 0) begin
                // two equal bits swallow the carry from the byte below
                // and hand sub_op on as the carry-in of the new element
                a_ext_d[9*k] = sub_op;
                b_ext_d[9*k] = sub_op;
            end else begin
                // 1 + 0 lets the carry of the lower byte ripple through
                a_ext_d[9*k] = 1'b1;
                b_ext_d[9*k] = 1'b0;
            end
        end
    end

    //////////////////////////////
    // stage register

    // the stage takes a new item when empty or when stage two drains it
    assign in_ready_o = ~valid_q | ex1_o.ready;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_ready_o && in_valid_i) begin
            ex1_o.op    <= op_i;
            ex1_o.ew    <= ew_i;
            ex1_o.a_ext <= a_ext_d;
            ex1_o.b_ext <= b_ext_d;
        end
    end

    assign ex1_o.valid = valid_q;

endmodule

`default_nettype wire

// File: alu_pkg.sv
// vector ALU shared definitions
// operand width, packed vector types, element widths and opcodes
`default_nettype none

package alu_pkg;

    // operand width and the number of byte lanes in it
    localparam int unsigned OP_W   = 64;
    localparam int unsigned NBYTES = OP_W / 8;

    typedef logic [OP_W-1:0]     word_t;
    // every byte lane gets a ninth bit below its data that steers the carry chain
    typedef logic [OP_W*9/8-1:0] ext_word_t;
    typedef logic [NBYTES-1:0]   byte_mask_t;

    typedef enum logic [1:0] {
        EW_8,
        EW_16,
        EW_32
    } elem_width_e;

    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_SADDU, OP_SADD, OP_SSUBU, OP_SSUB,
        OP_AND, OP_OR, OP_XOR,
        OP_MINU, OP_MIN, OP_MAXU, OP_MAX,
        OP_SEQ, OP_SNE, OP_SLTU, OP_SLT
    } alu_op_e;

    // opcodes that compute a minus b in the adder
    function automatic logic op_subtracts(alu_op_e op);
        case (op)
            OP_SUB, OP_SSUBU, OP_SSUB, OP_MINU, OP_MIN, OP_MAXU, OP_MAX,
            OP_SEQ, OP_SNE, OP_SLTU, OP_SLT: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // low byte index bits that address a byte inside one element
    function automatic int unsigned lane_mask(elem_width_e ew);
        case (ew)
            EW_16:   return 1;
            EW_32:   return 3;
            default: return 0;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: alu_result.sv
// vector ALU stage three
// picks the result per opcode, tests equality and holds the output register
`timescale 1ns/10ps
`default_nettype none

module alu_result #(
    parameter int unsigned OP_W = alu_pkg::OP_W
) (
    input  logic                clk_i,
    input  logic                async_rst_ni,
    ex2_if.dst                  ex2_i,
    output logic                out_valid_o,
    input  logic                out_ready_i,
    output alu_pkg::word_t      res_o,
    output alu_pkg::byte_mask_t cmp_o
);

    localparam int unsigned NB = OP_W / 8;

    alu_pkg::word_t      sum_bytes;
    alu_pkg::word_t      sel;
    logic [NB-1:0]       nz;
    logic [NB-1:0]       neq;
    alu_pkg::word_t      res_d;
    alu_pkg::byte_mask_t cmp_d;
    logic                stage_ready;
    logic                valid_q;

    always_comb begin
        for (int k = 0; k < NB; k++) begin
            sum_bytes[8*k +: 8] = ex2_i.sum[9*k+1 +: 8];
            sel[8*k +: 8]       = {8{ex2_i.flag[k]}};
            nz[k]               = |ex2_i.sum[9*k+1 +: 8];
        end
    end

    // a minus b is zero in every byte of the element exactly when a equals b
    always_comb begin
        for (int k = 0; k < NB; k++) begin
            int unsigned em;
            em     = alu_pkg::lane_mask(ex2_i.ew);
            neq[k] = 1'b0;
            for (int j = 0; j < 4; j++) begin
                if (j <= em) begin
                    neq[k] = neq[k] | nz[(k & ~em) + j];
                end
            end
        end
    end

    always_comb begin
        case (ex2_i.op)
            alu_pkg::OP_ADD, alu_pkg::OP_SUB:     res_d = sum_bytes;
            alu_pkg::OP_SADDU, alu_pkg::OP_SADD,
            alu_pkg::OP_SSUBU, alu_pkg::OP_SSUB:  res_d = (sel & ex2_i.satval) | (~sel & sum_bytes);
            alu_pkg::OP_AND:                      res_d = ex2_i.a & ex2_i.b;
            alu_pkg::OP_OR:                       res_d = ex2_i.a | ex2_i.b;
            alu_pkg::OP_XOR:                      res_d = ex2_i.a ^ ex2_i.b;
            // the flag says a is below b
            alu_pkg::OP_MINU, alu_pkg::OP_MIN:    res_d = (sel & ex2_i.a) | (~sel & ex2_i.b);
            alu_pkg::OP_MAXU, alu_pkg::OP_MAX:    res_d = (sel & ex2_i.b) | (~sel & ex2_i.a);
            default:                              res_d = '0;
        endcase
    end

    always_comb begin
        case (ex2_i.op)
            alu_pkg::OP_SEQ:                    cmp_d = ~neq;
            alu_pkg::OP_SNE:                    cmp_d = neq;
            alu_pkg::OP_SLTU, alu_pkg::OP_SLT:  cmp_d = ex2_i.flag;
            default:                            cmp_d = '0;
        endcase
    end

    //////////////////////////////
    // output register

    assign stage_ready = ~valid_q | out_ready_i;
    assign ex2_i.ready = stage_ready;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (stage_ready) begin
            valid_q <= ex2_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (stage_ready && ex2_i.valid) begin
            res_o <= res_d;
            cmp_o <= cmp_d;
        end
    end

    assign out_valid_o = valid_q;

endmodule

`default_nettype wire

// File: alu_stage_if.sv
// vector ALU stage interfaces
// ex1_if links operand prep to the adder, ex2_if links the adder to result select
`timescale 1ns/10ps
`default_nettype none

// decoded opcode and carry-chain operands leaving stage one
interface ex1_if;
    logic                 valid;
    logic                 ready;
    alu_pkg::alu_op_e     op;
    alu_pkg::elem_width_e ew;
    alu_pkg::ext_word_t   a_ext;
    alu_pkg::ext_word_t   b_ext;

    modport src (
        output valid, op, ew, a_ext, b_ext,
        input  ready
    );

    modport dst (
        input  valid, op, ew, a_ext, b_ext,
        output ready
    );
endinterface

// adder results leaving stage two, together with the plain operands
interface ex2_if;
    logic                 valid;
    logic                 ready;
    alu_pkg::alu_op_e     op;
    alu_pkg::elem_width_e ew;
    alu_pkg::ext_word_t   sum;
    alu_pkg::byte_mask_t  flag;
    alu_pkg::word_t       satval;
    alu_pkg::word_t       a;
    alu_pkg::word_t       b;

    modport src (
        output valid, op, ew, sum, flag, satval, a, b,
        input  ready
    );

    modport dst (
        input  valid, op, ew, sum, flag, satval, a, b,
        output ready
    );
endinterface

`default_nettype wire

// File: build.f
alu_pkg.sv
alu_stage_if.sv
alu_operand_prep.sv
alu_adder.sv
alu_result.sv
vec_alu.sv
vec_alu_checker.sv
tb_vec_alu.sv

// File: tb_vec_alu.sv
// testbench for the pipelined vector ALU
// applies a stimulus table twice, without and with random output back-pressure
`timescale 1ns/10ps
`default_nettype none

module tb_vec_alu;

    localparam int TIMEOUT = 1000;

    typedef struct {
        alu_pkg::alu_op_e     op;
        alu_pkg::elem_width_e ew;
        alu_pkg::word_t       a;
        alu_pkg::word_t       b;
        alu_pkg::word_t       res;
        alu_pkg::byte_mask_t  cmp;
        int                   cyc;
    } vec_entry_t;

    logic                 clk_i;
    logic                 async_rst_ni;
    logic                 in_valid_i;
    logic                 in_ready_o;
    alu_pkg::alu_op_e     op_i;
    alu_pkg::elem_width_e ew_i;
    alu_pkg::word_t       a_i;
    alu_pkg::word_t       b_i;
    logic                 out_valid_o;
    logic                 out_ready_i;
    alu_pkg::word_t       res_o;
    alu_pkg::byte_mask_t  cmp_o;

    vec_entry_t  tbl [0:511];
    vec_entry_t  exp_q [$];
    int          n_tbl;
    int          cur_idx;
    int          n_in;
    int          n_out;
    int          cyc;
    logic        bp_en;
    logic [31:0] lcg_state;

    vec_alu #(
        .OP_W (alu_pkg::OP_W)
    ) vec_alu_inst (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .op_i         (op_i),
        .ew_i         (ew_i),
        .a_i          (a_i),
        .b_i          (b_i),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .res_o        (res_o),
        .cmp_o        (cmp_o)
    );

    always #10 clk_i = ~clk_i;

    //////////////////////////////
    // helpers and reference model

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // per-element reference following the arithmetic rules of the ALU
    function automatic void alu_model(input alu_pkg::alu_op_e op, input alu_pkg::elem_width_e ew,
                                      input alu_pkg::word_t a, input alu_pkg::word_t b,
                                      output alu_pkg::word_t res, output alu_pkg::byte_mask_t cmp);
        int              w;
        longint unsigned lim;
        longint unsigned ea;
        longint unsigned eb;
        longint unsigned r;
        longint          sa;
        longint          sb;
        longint          sr;
        longint          smax;
        bit              c;
        w    = (ew == alu_pkg::EW_8) ? 8 : (ew == alu_pkg::EW_16) ? 16 : 32;
        lim  = (longint'(1) << w) - 1;
        smax = longint'(lim >> 1);
        res  = '0;
        cmp  = '0;
        for (int e = 0; e < alu_pkg::OP_W / w; e++) begin
            ea = (a >> (e * w)) & lim;
            eb = (b >> (e * w)) & lim;
            sa = (ea > smax) ? longint'(ea) - longint'(lim) - 1 : longint'(ea);
            sb = (eb > smax) ? longint'(eb) - longint'(lim) - 1 : longint'(eb);
            r  = 0;
            c  = 1'b0;
            case (op)
                alu_pkg::OP_ADD:   r = ea + eb;
                alu_pkg::OP_SUB:   r = ea - eb;
                alu_pkg::OP_SADDU: r = (ea + eb > lim) ? lim : ea + eb;
                alu_pkg::OP_SSUBU: r = (ea < eb) ? 0 : ea - eb;
                alu_pkg::OP_SADD, alu_pkg::OP_SSUB: begin
                    sr = (op == alu_pkg::OP_SADD) ? sa + sb : sa - sb;
                    if (sr > smax) sr = smax;
                    if (sr < -smax - 1) sr = -smax - 1;
                    r = longint'(sr);
                end
                alu_pkg::OP_AND:   r = ea & eb;
                alu_pkg::OP_OR:    r = ea | eb;
                alu_pkg::OP_XOR:   r = ea ^ eb;
                alu_pkg::OP_MINU:  r = (ea < eb) ? ea : eb;
                alu_pkg::OP_MAXU:  r = (ea < eb) ? eb : ea;
                alu_pkg::OP_MIN:   r = (sa < sb) ? ea : eb;
                alu_pkg::OP_MAX:   r = (sa < sb) ? eb : ea;
                alu_pkg::OP_SEQ:   c = (ea == eb);
                alu_pkg::OP_SNE:   c = (ea != eb);
                alu_pkg::OP_SLTU:  c = (ea < eb);
                alu_pkg::OP_SLT:   c = (sa < sb);
                default:           r = 0;
            endcase
            res = res | (alu_pkg::word_t'(r & lim) << (e * w));
            for (int k = 0; k < w / 8; k++) begin
                cmp[e * (w / 8) + k] = c;
            end
        end
    endfunction

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_res(input alu_pkg::word_t got, input alu_pkg::word_t exp, input int idx);
        if (got !== exp) begin
            $display("[FAIL] time %0d ns: item %0d res_o %h, expected %h", $time, idx, got, exp);
            abort_run();
        end
    endtask

    task automatic check_cmp(input alu_pkg::byte_mask_t got, input alu_pkg::byte_mask_t exp,
                             input int idx);
        if (got !== exp) begin
            $display("[FAIL] time %0d ns: item %0d cmp_o %b, expected %b", $time, idx, got, exp);
            abort_run();
        end
    endtask

    task automatic add_entry(input alu_pkg::alu_op_e op, input alu_pkg::elem_width_e ew,
                             input alu_pkg::word_t a, input alu_pkg::word_t b);
        tbl[n_tbl].op = op;
        tbl[n_tbl].ew = ew;
        tbl[n_tbl].a  = a;
        tbl[n_tbl].b  = b;
        alu_model(op, ew, a, b, tbl[n_tbl].res, tbl[n_tbl].cmp);
        n_tbl++;
    endtask

    // every opcode at every width gets four edge pairs and two random pairs
    task automatic build_table();
        alu_pkg::word_t ea [0:3];
        alu_pkg::word_t eb [0:3];
        alu_pkg::word_t ra;
        alu_pkg::word_t rb;
        ea[0] = 64'hFFFF_FFFF_FFFF_FFFF;
        eb[0] = 64'h0101_0101_0101_0101;
        ea[1] = 64'h7FFF_FFFF_8000_0000;
        eb[1] = 64'h0001_0001_0000_0001;
        ea[2] = 64'h8000_7F80_7FFF_FFFF;
        eb[2] = 64'h7FFF_8001_8000_0001;
        ea[3] = 64'h0000_1234_0000_00FF;
        eb[3] = 64'h0000_1234_0001_00FF;
        n_tbl = 0;
        for (int o = 0; o < 17; o++) begin
            for (int w = 0; w < 3; w++) begin
                for (int p = 0; p < 4; p++) begin
                    add_entry(alu_pkg::alu_op_e'(o), alu_pkg::elem_width_e'(w), ea[p], eb[p]);
                end
                for (int p = 0; p < 2; p++) begin
                    ra = '0;
                    rb = '0;
                    for (int i = 0; i < alu_pkg::OP_W / 32; i++) begin
                        ra = (ra << 32) | alu_pkg::word_t'(lcg_next());
                        rb = (rb << 32) | alu_pkg::word_t'(lcg_next());
                    end
                    // the second pair differs from a in only a few bits
                    if (p == 1) begin
                        rb = ra ^ (alu_pkg::word_t'(lcg_next()) & 64'h0101_0000);
                    end
                    add_entry(alu_pkg::alu_op_e'(o), alu_pkg::elem_width_e'(w), ra, rb);
                end
            end
        end
    endtask

    //////////////////////////////
    // stimulus

    task automatic drive_ready();
        logic [31:0] r;
        r = lcg_next();
        out_ready_i = bp_en ? r[30] : 1'b1;
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic apply_entry(input int idx);
        int waited;
        waited     = 0;
        cur_idx    = idx;
        op_i       = tbl[idx].op;
        ew_i       = tbl[idx].ew;
        a_i        = tbl[idx].a;
        b_i        = tbl[idx].b;
        in_valid_i = 1'b1;
        drive_ready();
        @(posedge clk_i);
        while (!in_ready_o) begin
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout: in_ready_o stayed low for entry %0d", idx);
                abort_run();
            end
            @(negedge clk_i);
            drive_ready();
            @(posedge clk_i);
        end
        @(negedge clk_i);
    endtask

    task automatic drain_pipeline();
        int waited;
        waited      = 0;
        in_valid_i  = 1'b0;
        out_ready_i = 1'b1;
        while (n_in != n_out) begin
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout: %0d results never left the pipeline", n_in - n_out);
                abort_run();
            end
            @(negedge clk_i);
        end
    endtask

    //////////////////////////////
    // scoreboard

    always @(posedge clk_i) begin : scoreboard
        vec_entry_t e;
        if (async_rst_ni) begin
            if (!in_ready_o && (!bp_en || n_in - n_out != 3)) begin
                $display("in_ready_o fell with %0d items in the pipeline", n_in - n_out);
                abort_run();
            end
            if (out_valid_o && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("a result appeared with no input outstanding");
                    abort_run();
                end
                e = exp_q.pop_front();
                check_res(res_o, e.res, n_out);
                check_cmp(cmp_o, e.cmp, n_out);
                if (!bp_en && cyc != e.cyc + 3) begin
                    $display("[FAIL] time %0d ns: item %0d took %0d cycles, expected 3",
                             $time, n_out, cyc - e.cyc);
                    abort_run();
                end
                n_out++;
            end
            if (in_valid_i && in_ready_o) begin
                e     = tbl[cur_idx];
                e.cyc = cyc;
                exp_q.push_back(e);
                n_in++;
            end
            cyc++;
        end
    end

    initial begin
        lcg_state    = 32'd15989;
        clk_i        = 1'b0;
        async_rst_ni = 1'b0;
        in_valid_i   = 1'b0;
        out_ready_i  = 1'b1;
        op_i         = alu_pkg::OP_ADD;
        ew_i         = alu_pkg::EW_8;
        a_i          = '0;
        b_i          = '0;
        bp_en        = 1'b0;
        cur_idx      = 0;
        n_in         = 0;
        n_out        = 0;
        cyc          = 0;
        build_table();
        repeat (4) @(negedge clk_i);
        async_rst_ni = 1'b1;
        // first pass checks latency, second pass adds random back-pressure
        for (int pass = 0; pass < 2; pass++) begin
            bp_en = (pass == 1);
            for (int i = 0; i < n_tbl; i++) begin
                apply_entry(i);
            end
            drain_pipeline();
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vec_alu.sv
// pipelined vector integer ALU
// three registered stages behind a valid/ready handshake
`timescale 1ns/10ps
`default_nettype none

module vec_alu #(
    parameter int unsigned OP_W = alu_pkg::OP_W
) (
    input  logic                 clk_i,
    input  logic                 async_rst_ni,
    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    input  alu_pkg::alu_op_e     op_i,
    input  alu_pkg::elem_width_e ew_i,
    input  alu_pkg::word_t       a_i,
    input  alu_pkg::word_t       b_i,
    output logic                 out_valid_o,
    input  logic                 out_ready_i,
    output alu_pkg::word_t       res_o,
    output alu_pkg::byte_mask_t  cmp_o
);

    // the adder works in 32-bit slices and the types come from the package
    if (OP_W != alu_pkg::OP_W || OP_W % 32 != 0) begin : g_width_check
        $error("vec_alu: OP_W must equal alu_pkg::OP_W and be a multiple of 32");
    end

    ex1_if ex1_bus ();
    ex2_if ex2_bus ();

    alu_operand_prep #(
        .OP_W (OP_W)
    ) operand_prep_inst (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .op_i         (op_i),
        .ew_i         (ew_i),
        .a_i          (a_i),
        .b_i          (b_i),
        .ex1_o        (ex1_bus.src)
    );

    alu_adder #(
        .OP_W (OP_W)
    ) adder_inst (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .ex1_i        (ex1_bus.dst),
        .ex2_o        (ex2_bus.src)
    );

    alu_result #(
        .OP_W (OP_W)
    ) result_inst (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .ex2_i        (ex2_bus.dst),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .res_o        (res_o),
        .cmp_o        (cmp_o)
    );

endmodule

`default_nettype wire

// File: vec_alu_checker.sv
// handshake assertions for the vector ALU, bound to the top level
`timescale 1ns/10ps
`default_nettype none

module vec_alu_checker (
    input logic                clk_i,
    input logic                async_rst_ni,
    input logic                in_ready_i,
    input logic                out_valid_i,
    input logic                out_ready_i,
    input alu_pkg::word_t      res_i,
    input alu_pkg::byte_mask_t cmp_i,
    input logic                s1_valid_i,
    input logic                s2_valid_i
);

    // a result that is not taken stays on the outputs unchanged
    a_out_hold: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(res_i) && $stable(cmp_i))
        else $error("output changed while a result was waiting");

    // every stage leaves reset empty, so nothing reaches the output for three edges
    a_reset_idle: assert property (@(posedge clk_i)
        $rose(async_rst_ni) |-> !out_valid_i ##1 !out_valid_i ##1 !out_valid_i)
        else $error("out_valid_o high too soon after reset");

    // a free slot anywhere in the pipeline keeps the input open
    a_empty_ready: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        !(s1_valid_i && s2_valid_i && out_valid_i) |-> in_ready_i)
        else $error("in_ready_o low while a stage was empty");

endmodule

bind vec_alu vec_alu_checker checker_inst (
    .clk_i        (clk_i),
    .async_rst_ni (async_rst_ni),
    .in_ready_i   (in_ready_o),
    .out_valid_i  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .res_i        (res_o),
    .cmp_i        (cmp_o),
    .s1_valid_i   (ex1_bus.valid),
    .s2_valid_i   (ex2_bus.valid)
);

`default_nettype wire
